// File: design/dcache_lookup.sv
`default_nettype none

`include "dcache_macros.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req_valid,
    input  cpu_req_t                         req,
    output logic                             req_ready,
    output logic                             resp_valid,
    output cpu_resp_t                        resp,
    input  logic                             resp_ready,
    output index_t                           rd_index,
    input  tag_entry_t [`DCACHE_WAYS-1:0]    rd_tags,
    input  line_t      [`DCACHE_WAYS-1:0]    rd_lines,
    output logic       [`DCACHE_WAYS-1:0]    hit_we,
    output index_t                           hit_index,
    output line_t                            hit_line,
    output logic                             hit_dirty,
    output logic                             miss,
    output index_t                           miss_index,
    output tag_t                             miss_tag,
    input  logic                             fill_done
);

    localparam int IDX_LSB = `DCACHE_OFFSET_W + 2;
    localparam int TAG_LSB = IDX_LSB + `DCACHE_INDEX_W;

    logic                        ready_en;
    logic                        acc_valid;
    cpu_req_t                    acc_req;
    logic                        lk_valid;
    cpu_req_t                    lk_req;
    tag_t                        lk_tag;
    logic [`DCACHE_OFFSET_W-1:0] lk_offset;
    logic [`DCACHE_WAYS-1:0]     hit_way;
    logic                        lk_hit;
    logic                        lk_fire;
    logic                        lk_adv;
    line_t                       sel_line;
    line_t                       merged_line;
    logic                        miss_q;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] out_word;
        out_word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                out_word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return out_word;
    endfunction

    assign rd_index  = lk_req.addr[IDX_LSB +: `DCACHE_INDEX_W];
    assign lk_tag    = lk_req.addr[TAG_LSB +: `DCACHE_TAG_W];
    assign lk_offset = lk_req.addr[2 +: `DCACHE_OFFSET_W];

    // Tag compare across ways and byte merge into the hit line
    always_comb begin
        sel_line = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_way[w] = rd_tags[w].valid && (rd_tags[w].tag == lk_tag);
            if (hit_way[w]) begin
                sel_line = rd_lines[w];
            end
        end
        merged_line = sel_line;
        merged_line[lk_offset] = merge_bytes(sel_line[lk_offset], lk_req.wdata, lk_req.be);
    end

    assign lk_hit    = lk_valid && (|hit_way);
    assign lk_fire   = lk_hit && (!resp_valid || resp_ready);
    assign lk_adv    = !lk_valid || lk_fire;
    assign req_ready = ready_en && (!acc_valid || lk_adv);

    // Write hits only commit once the response can move
    assign hit_we     = {`DCACHE_WAYS{lk_fire && lk_req.write}} & hit_way;
    assign hit_index  = rd_index;
    assign hit_line   = merged_line;
    assign hit_dirty  = lk_req.write;
    assign miss       = miss_q;
    assign miss_index = rd_index;
    assign miss_tag   = lk_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en   <= 1'b0;
            acc_valid  <= 1'b0;
            lk_valid   <= 1'b0;
            resp_valid <= 1'b0;
            miss_q     <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (req_valid && req_ready) begin
                acc_valid <= 1'b1;
            end else if (lk_adv) begin
                acc_valid <= 1'b0;
            end
            if (lk_adv) begin
                lk_valid <= acc_valid;
            end
            if (lk_fire) begin
                resp_valid <= 1'b1;
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
            // Held until the refilled line is installed, then the request retries
            if (fill_done) begin
                miss_q <= 1'b0;
            end else if (lk_valid && !lk_hit) begin
                miss_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            acc_req <= req;
        end
        if (lk_adv && acc_valid) begin
            lk_req <= acc_req;
        end
        if (lk_fire) begin
            resp.rdata <= lk_req.write ? merged_line[lk_offset] : sel_line[lk_offset];
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_miss_unit.sv
`default_nettype none

`include "dcache_macros.svh"

module dcache_miss_unit
    import dcache_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             miss,
    input  index_t                           miss_index,
    input  tag_t                             miss_tag,
    input  tag_entry_t [`DCACHE_WAYS-1:0]    rd_tags,
    input  line_t      [`DCACHE_WAYS-1:0]    rd_lines,
    output logic                             fill_we,
    output fill_t                            fill,
    output logic                             fill_done,
    output mem_req_t                         mem_req,
    input  mem_resp_t                        mem_resp
);

    localparam int LINE_OFF_W = `DCACHE_OFFSET_W + 2;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AW,
        ST_W,
        ST_B,
        ST_AR,
        ST_R,
        ST_FILL
    } state_t;

    state_t                    state;
    logic [7:0]                lfsr;
    logic [7:0]                lfsr_next;
    way_t                      pick_way;
    logic [`DCACHE_BEAT_W-1:0] beat;
    way_t                      victim_way;
    tag_t                      victim_tag;
    line_t                     victim_line;
    line_t                     rx_line;

    // Taps 8,6,5,4 for a maximal length sequence
    assign lfsr_next = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    assign pick_way  = lfsr_next[$bits(way_t)-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            lfsr  <= `DCACHE_LFSR_SEED;
            beat  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (miss) begin
                        lfsr <= lfsr_next;
                        // Clean or empty victims skip the write-back
                        if (rd_tags[pick_way].valid && rd_tags[pick_way].dirty) begin
                            state <= ST_AW;
                        end else begin
                            state <= ST_AR;
                        end
                    end
                end
                ST_AW: begin
                    if (mem_resp.aw_ready) begin
                        state <= ST_W;
                        beat  <= '0;
                    end
                end
                ST_W: begin
                    if (mem_resp.w_ready) begin
                        beat <= beat + 1'b1;
                        if (beat == `DCACHE_LAST_BEAT) begin
                            state <= ST_B;
                        end
                    end
                end
                ST_B: begin
                    if (mem_resp.b_valid) begin
                        state <= ST_AR;
                    end
                end
                ST_AR: begin
                    if (mem_resp.ar_ready) begin
                        state <= ST_R;
                        beat  <= '0;
                    end
                end
                ST_R: begin
                    if (mem_resp.r_valid) begin
                        beat <= beat + 1'b1;
                        if (mem_resp.r_last) begin
                            state <= ST_FILL;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Victim snapshot and refill buffer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && miss) begin
            victim_way  <= pick_way;
            victim_tag  <= rd_tags[pick_way].tag;
            victim_line <= rd_lines[pick_way];
        end
        if (state == ST_R && mem_resp.r_valid) begin
            rx_line[beat] <= mem_resp.r_data;
        end
    end

    always_comb begin
        mem_req          = '0;
        mem_req.aw_addr  = {victim_tag, miss_index, {LINE_OFF_W{1'b0}}};
        mem_req.ar_addr  = {miss_tag, miss_index, {LINE_OFF_W{1'b0}}};
        mem_req.w_data   = victim_line[beat];
        mem_req.w_last   = (state == ST_W) && (beat == `DCACHE_LAST_BEAT);
        mem_req.aw_valid = (state == ST_AW);
        mem_req.w_valid  = (state == ST_W);
        mem_req.ar_valid = (state == ST_AR);
        mem_req.r_ready  = (state == ST_R);
    end

    assign fill_we    = (state == ST_FILL);
    assign fill_done  = (state == ST_FILL);
    assign fill.way   = victim_way;
    assign fill.index = miss_index;
    assign fill.tag   = miss_tag;
    assign fill.line  = rx_line;

endmodule

`default_nettype wire

// File: design/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DCACHE_INDEX_W-1:0]      index_t;
    typedef logic [`DCACHE_TAG_W-1:0]        tag_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;
    typedef logic [`DCACHE_WORDS-1:0][31:0]  line_t;

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // Cache to memory
    typedef struct packed {
        logic        ar_valid;
        logic [31:0] ar_addr;
        logic        r_ready;
        logic        aw_valid;
        logic [31:0] aw_addr;
        logic        w_valid;
        logic [31:0] w_data;
        logic        w_last;
    } mem_req_t;

    // Memory to cache
    // The write response is always accepted
    typedef struct packed {
        logic        ar_ready;
        logic        r_valid;
        logic [31:0] r_data;
        logic        r_last;
        logic        aw_ready;
        logic        w_ready;
        logic        b_valid;
    } mem_resp_t;

    typedef struct packed {
        way_t   way;
        index_t index;
        tag_t   tag;
        line_t  line;
    } fill_t;

endpackage

`default_nettype wire

// File: design/dcache_store.sv
`default_nettype none

`include "dcache_macros.svh"

module dcache_store
    import dcache_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic       [`DCACHE_WAYS-1:0]    hit_we,
    input  index_t                           hit_index,
    input  line_t                            hit_line,
    input  logic                             hit_dirty,
    input  logic                             fill_we,
    input  fill_t                            fill,
    input  index_t                           rd_index,
    output tag_entry_t [`DCACHE_WAYS-1:0]    rd_tags,
    output line_t      [`DCACHE_WAYS-1:0]    rd_lines
);

    logic  valid_q [`DCACHE_WAYS][`DCACHE_SETS];
    logic  dirty_q [`DCACHE_WAYS][`DCACHE_SETS];
    tag_t  tag_q   [`DCACHE_WAYS][`DCACHE_SETS];
    line_t data_q  [`DCACHE_WAYS][`DCACHE_SETS];

    // Valid bits per way and set
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else if (fill_we) begin
            valid_q[fill.way][fill.index] <= 1'b1;
        end
    end

    // Fill wins over a hit write to the same way
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (fill_we && fill.way == way_t'(w)) begin
                tag_q[w][fill.index]   <= fill.tag;
                dirty_q[w][fill.index] <= 1'b0;
                data_q[w][fill.index]  <= fill.line;
            end else if (hit_we[w]) begin
                dirty_q[w][hit_index] <= hit_dirty;
                data_q[w][hit_index]  <= hit_line;
            end
        end
    end

    // Combinational read of every way at one index
    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : gen_read
        assign rd_tags[w].valid = valid_q[w][rd_index];
        assign rd_tags[w].dirty = dirty_q[w][rd_index];
        assign rd_tags[w].tag   = tag_q[w][rd_index];
        assign rd_lines[w]      = data_q[w][rd_index];
    end

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`default_nettype none

`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  cpu_req_t  req,
    output logic      req_ready,
    output logic      resp_valid,
    output cpu_resp_t resp,
    input  logic      resp_ready,
    output mem_req_t  mem_req,
    input  mem_resp_t mem_resp
);

    index_t                        rd_index;
    tag_entry_t [`DCACHE_WAYS-1:0] rd_tags;
    line_t      [`DCACHE_WAYS-1:0] rd_lines;
    logic       [`DCACHE_WAYS-1:0] hit_we;
    index_t                        hit_index;
    line_t                         hit_line;
    logic                          hit_dirty;
    logic                          miss;
    index_t                        miss_index;
    tag_t                          miss_tag;
    logic                          fill_we;
    fill_t                         fill;
    logic                          fill_done;

    dcache_store dcache_store_inst (
        .clk, .rst, .hit_we, .hit_index, .hit_line, .hit_dirty,
        .fill_we, .fill, .rd_index, .rd_tags, .rd_lines
    );

    dcache_lookup dcache_lookup_inst (
        .clk, .rst, .req_valid, .req, .req_ready, .resp_valid, .resp, .resp_ready,
        .rd_index, .rd_tags, .rd_lines, .hit_we, .hit_index, .hit_line, .hit_dirty,
        .miss, .miss_index, .miss_tag, .fill_done
    );

    // Victim is read through the same store port while lookup holds the miss
    dcache_miss_unit dcache_miss_unit_inst (
        .clk, .rst, .miss, .miss_index, .miss_tag, .rd_tags, .rd_lines,
        .fill_we, .fill, .fill_done, .mem_req, .mem_resp
    );

endmodule

`default_nettype wire

// File: include/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Cache geometry
`define DCACHE_WAYS      2
`define DCACHE_SETS      8
`define DCACHE_WORDS     4
`define DCACHE_INDEX_W   3
`define DCACHE_OFFSET_W  2

// Address bits above the index and the 4 line-byte bits
`define DCACHE_TAG_W     (32 - `DCACHE_INDEX_W - `DCACHE_OFFSET_W - 2)

// Every burst moves one full line
`define DCACHE_BEAT_W    2
`define DCACHE_LAST_BEAT 2'd3

// Must be nonzero or the LFSR locks up
`define DCACHE_LFSR_SEED 8'h5b

`endif

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module dcache_tb -o dcache_sim \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1
grep -q "Errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sim.f
+incdir+include
design/dcache_pkg.sv
design/dcache_store.sv
design/dcache_lookup.sv
design/dcache_miss_unit.sv
design/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: verification/dcache_assertions.sv
`default_nettype none

`include "dcache_macros.svh"

module dcache_assertions
    import dcache_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      resp_valid,
    input logic      resp_ready,
    input cpu_resp_t resp,
    input mem_req_t  mem_req,
    input mem_resp_t mem_resp
);

    logic [`DCACHE_BEAT_W-1:0] w_cnt;

    // Counts accepted W beats within the current burst
    always_ff @(posedge clk) begin
        if (rst) begin
            w_cnt <= '0;
        end else if (mem_req.w_valid && mem_resp.w_ready) begin
            w_cnt <= w_cnt + 1'b1;
        end
    end

    resp_stable: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> $stable(resp))
        else $error("resp changed while stalled");

    w_last_beat: assert property (@(posedge clk) disable iff (rst)
        mem_req.w_valid |-> (mem_req.w_last == (w_cnt == `DCACHE_LAST_BEAT)))
        else $error("w_last not on the fourth beat");

    ar_aw_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.ar_valid && mem_req.aw_valid))
        else $error("ar_valid and aw_valid high together");

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req.ar_valid && !mem_resp.ar_ready |=> mem_req.ar_valid)
        else $error("ar_valid dropped before ar_ready");

endmodule

bind dcache_top dcache_assertions dcache_assertions_inst (.*);

`default_nettype wire

// File: verification/dcache_tb.sv
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb
    import dcache_pkg::*;
();

    typedef struct packed {
        logic        write;
        logic        fast;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [31:0] exp;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    cpu_req_t    req;
    logic        req_ready;
    logic        resp_valid;
    cpu_resp_t   resp;
    logic        resp_ready = 1'b0;
    mem_req_t    mem_req;
    mem_resp_t   mem_resp = '0;
    logic [31:0] mem [256];
    logic [31:0] shadow [256];
    logic        rd_active;
    logic [1:0]  rd_beat;
    logic [5:0]  rd_line;
    logic [5:0]  wr_line;
    logic [1:0]  wr_beat;
    logic [31:0] seed = 32'h12b7_a8d3;
    int          cyc = 0;
    int          limit = 2000;
    int          fast_cnt = 0;
    row_t        table_q [$];
    row_t        pend_q [$];
    int          acc_q [$];

    dcache_top dcache_top_inst (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] apply_be(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s (got %h, expected %h)",
                     $time, msg, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Expected data comes from the shadow copy of memory
    task automatic add_row(input logic w, input logic f, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] be);
        row_t r;
        if (w) begin
            shadow[addr[9:2]] = apply_be(shadow[addr[9:2]], data, be);
        end
        r = '{write: w, fast: f, addr: addr, data: data, be: be, exp: shadow[addr[9:2]]};
        table_q.push_back(r);
    endtask

    task automatic build_table();
        for (int i = 0; i < 256; i++) begin
            shadow[i] = i ^ 32'h5a5a_0000;
        end
        add_row(0, 0, 32'h000, 0, 0);
        add_row(0, 1, 32'h004, 0, 0);
        add_row(1, 0, 32'h008, 32'haabb_ccdd, 4'b0101);
        add_row(0, 0, 32'h008, 0, 0);
        add_row(1, 0, 32'h00c, 32'h1234_5678, 4'b1000);
        add_row(0, 0, 32'h00c, 0, 0);
        add_row(0, 0, 32'h010, 0, 0);
        add_row(0, 0, 32'h030, 0, 0);
        add_row(0, 0, 32'h040, 0, 0);
        // Back to back hits in different sets
        add_row(0, 1, 32'h014, 0, 0);
        add_row(0, 1, 32'h034, 0, 0);
        add_row(0, 1, 32'h048, 0, 0);
        add_row(0, 1, 32'h004, 0, 0);
        add_row(1, 1, 32'h018, 32'hcafe_f00d, 4'b1111);
        add_row(1, 1, 32'h01c, 32'h0bad_beef, 4'b0110);
        add_row(0, 1, 32'h01c, 0, 0);
        // Four dirty lines in set 2 force write-backs
        add_row(1, 0, 32'h020, 32'h1111_1111, 4'b1111);
        add_row(1, 0, 32'h0a0, 32'h2222_2222, 4'b1111);
        add_row(1, 0, 32'h124, 32'h3333_3333, 4'b1111);
        add_row(1, 0, 32'h1a8, 32'h4444_4444, 4'b0011);
        add_row(0, 0, 32'h020, 0, 0);
        add_row(0, 0, 32'h0a0, 0, 0);
        add_row(0, 0, 32'h124, 0, 0);
        add_row(0, 0, 32'h1a8, 0, 0);
        add_row(0, 0, 32'h0a4, 0, 0);
        add_row(0, 0, 32'h300, 0, 0);
        add_row(0, 0, 32'h380, 0, 0);
        add_row(0, 0, 32'h008, 0, 0);
        add_row(1, 0, 32'h384, 32'hdead_beef, 4'b1100);
        add_row(0, 0, 32'h384, 0, 0);
        add_row(0, 0, 32'h00c, 0, 0);
        // Worst miss with stalls stays well under 64 cycles
        limit = table_q.size() * 64;
    endtask

    // Memory model with random ready and valid drops
    always @(posedge clk) begin : mem_model
        logic [31:0] rnd;
        logic        nact;
        logic [1:0]  nbeat;
        logic [5:0]  nline;
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= i ^ 32'h5a5a_0000;
            end
            mem_resp   <= '0;
            resp_ready <= 1'b0;
            rd_active  <= 1'b0;
            rd_beat    <= '0;
            rd_line    <= '0;
            wr_line    <= '0;
            wr_beat    <= '0;
        end else begin
            rnd = lcg_next();
            resp_ready        <= (fast_cnt > 0) || (rnd[25:24] != 2'b00);
            mem_resp.ar_ready <= rnd[17:16] != 2'b00;
            mem_resp.aw_ready <= rnd[19:18] != 2'b00;
            mem_resp.w_ready  <= rnd[21:20] != 2'b00;
            mem_resp.b_valid  <= 1'b0;
            nact  = rd_active;
            nbeat = rd_beat;
            nline = rd_line;
            if (mem_req.ar_valid && mem_resp.ar_ready) begin
                nact  = 1'b1;
                nbeat = '0;
                nline = mem_req.ar_addr[9:4];
            end else if (mem_resp.r_valid && mem_req.r_ready) begin
                nact  = (rd_beat != 2'd3);
                nbeat = rd_beat + 1'b1;
            end
            rd_active        <= nact;
            rd_beat          <= nbeat;
            rd_line          <= nline;
            mem_resp.r_valid <= nact && (rnd[23:22] != 2'b00);
            mem_resp.r_data  <= mem[{nline, nbeat}];
            mem_resp.r_last  <= (nbeat == 2'd3);
            if (mem_req.aw_valid && mem_resp.aw_ready) begin
                wr_line <= mem_req.aw_addr[9:4];
                wr_beat <= '0;
            end
            if (mem_req.w_valid && mem_resp.w_ready) begin
                mem[{wr_line, wr_beat}] <= mem_req.w_data;
                wr_beat <= wr_beat + 1'b1;
                if (mem_req.w_last) begin
                    mem_resp.b_valid <= 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("Timeout: the test did not complete within %0d cycles", limit);
            $display("Errors found");
            $fatal(1);
        end
    end

    // Responses are checked in request order
    always @(negedge clk) begin : resp_check
        row_t r;
        int   acc;
        if (!rst && resp_valid && resp_ready) begin
            if (pend_q.size() == 0) begin
                $display("A response arrived with no request outstanding");
                $display("Errors found");
                $fatal(1);
            end
            r   = pend_q.pop_front();
            acc = acc_q.pop_front();
            check(resp.rdata, r.exp, $sformatf("response data for address %h", r.addr));
            if (r.fast) begin
                check(cyc - acc, 2, $sformatf("hit latency for address %h", r.addr));
                fast_cnt--;
            end
        end
        if (fast_cnt > 0) begin
            check(32'(mem_req.ar_valid), 32'd0, "ar_valid during a hit");
        end
    end

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check(32'(resp_valid), 32'd0, "resp_valid after reset");
        check(32'(mem_req.ar_valid), 32'd0, "ar_valid after reset");
        check(32'(mem_req.aw_valid), 32'd0, "aw_valid after reset");
        check(32'(mem_req.w_valid), 32'd0, "w_valid after reset");
        @(posedge clk);
        for (int i = 0; i < table_q.size(); i++) begin
            // A run of timed hits starts with an empty pipeline
            if (table_q[i].fast && (i == 0 || !table_q[i-1].fast)) begin
                req_valid <= 1'b0;
                while (pend_q.size() != 0) begin
                    @(posedge clk);
                end
            end
            req_valid <= 1'b1;
            req <= '{write: table_q[i].write, addr: table_q[i].addr,
                     wdata: table_q[i].data, be: table_q[i].be};
            do begin
                @(negedge clk);
                // Hits that follow a hit are taken one per cycle
                if (table_q[i].fast && i > 0 && table_q[i-1].fast) begin
                    check(32'(req_ready), 32'd1, "req_ready during back to back hits");
                end
            end while (!req_ready);
            pend_q.push_back(table_q[i]);
            acc_q.push_back(cyc + 1);
            if (table_q[i].fast) begin
                fast_cnt++;
            end
            @(posedge clk);
        end
        req_valid <= 1'b0;
        while (pend_q.size() != 0) begin
            @(posedge clk);
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
